// File: sources.f
+incdir+design
design/swarm_pkg.sv
design/tile_hash.sv
design/tsb.sv
design/lvt_scan.sv
design/tsb_top.sv
test/tsb_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tsb_tb -f sources.f -o tsb_sim

out=$(./obj_dir/tsb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
   exit 0
fi
exit 1

// File: test/tsb_tb.sv
`timescale 1ns/1ps
`include "swarm_cfg.svh"

module tsb_tb;
   import swarm_pkg::*;

   // the tests take roughly 700 cycles
   localparam int CYCLE_LIMIT = 4000;

   logic          clk = 1'b0;
   logic          rstn;
   logic          s_wvalid;
   logic          s_wready;
   task_t         s_wdata;
   logic          s_tied;
   cq_slot_t      s_cq_slot;
   child_id_t     s_child_id;
   logic          reg_wvalid;
   reg_addr_t     reg_waddr;
   reg_word_u     reg_wdata;
   logic          reg_arvalid;
   reg_addr_t     reg_araddr;
   logic          reg_rvalid;
   reg_data_t     reg_rdata;
   logic          task_enq_valid;
   logic          task_enq_ready;
   task_t         task_enq_data;
   logic          task_enq_tied;
   tile_id_t      task_enq_dest_tile;
   tsb_entry_id_t task_enq_tsb_id;
   logic          retry_valid;
   logic          retry_ready;
   tsb_entry_id_t retry_tsb_id;
   logic          retry_abort;
   logic          retry_tied;
   logic          task_resp_valid;
   logic          task_resp_ready;
   logic          task_resp_ack;
   tsb_entry_id_t task_resp_tsb_id;
   epoch_t        task_resp_epoch;
   tq_slot_t      task_resp_tq_slot;
   logic          m_resp_valid;
   logic          m_resp_ready;
   logic          m_resp_ack;
   tsb_entry_id_t m_tsb_slot;
   epoch_t        m_epoch;
   tq_slot_t      m_tq_slot;
   tile_id_t      m_tile_id;
   cq_slot_t      m_cq_slot;
   child_id_t     m_child_id;
   logic          almost_full;
   logic          empty;
   ts_t           lvt;

   logic [31:0]   lfsr = 32'd57;
   logic [31:0]   stall_lfsr = 32'd57;
   logic          stall_en = 1'b0;
   int            cycles = 0;
   int            checks = 0;
   int            errors = 0;
   int            test_errors = 0;
   int            tests_run = 0;

   // hash setup as last written
   logic [31:0]   hash_key_cfg = '0;
   logic [31:0]   n_tiles_cfg = `N_TILES_RESET;

   // tile model records
   task_t         enq_data_q[$];
   tile_id_t      enq_tile_q[$];
   tsb_entry_id_t enq_id_q[$];
   logic          enq_tied_q[$];
   logic [29:0]   mresp_q[$];

   tsb_top tsb_top_inst (.*);

   always #50 clk = ~clk;

   function automatic logic [31:0] galois_step(input logic [31:0] s);
      // x^32 + x^22 + x^2 + x + 1
      galois_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = galois_step(lfsr);
      end
   endtask

   task automatic rand_task(output task_t t);
      logic [31:0] w;
      rand_bits(32, w);
      t.ts = w;
      rand_bits(32, w);
      t.locale = w;
      rand_bits(32, w);
      t.arg = w;
   endtask

   // destination tile by the routing rule
   function automatic logic [31:0] route_tile(input logic [31:0] locale);
      route_tile = ((locale ^ hash_key_cfg) >> 4) % n_tiles_cfg;
   endfunction

   always @(posedge clk) begin
      if (task_enq_valid && task_enq_ready) begin
         enq_data_q.push_back(task_enq_data);
         enq_tile_q.push_back(task_enq_dest_tile);
         enq_id_q.push_back(task_enq_tsb_id);
         enq_tied_q.push_back(task_enq_tied);
      end
      if (m_resp_valid && m_resp_ready) begin
         mresp_q.push_back({m_resp_ack, m_tsb_slot, m_epoch, m_tq_slot,
                            m_tile_id, m_cq_slot, m_child_id});
      end
      // random stall of the tile's enqueue port
      if (stall_en) begin
         stall_lfsr = galois_step(stall_lfsr);
         task_enq_ready <= stall_lfsr[0];
      end else begin
         task_enq_ready <= 1'b1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [95:0] actual,
                              input logic [95:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
                  $time, name, actual, expected);
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      $display("test %s done, %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
      @(posedge clk);
      reg_wvalid <= 1'b1;
      reg_waddr  <= addr;
      reg_wdata  <= data;
      @(posedge clk);
      reg_wvalid <= 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output logic [31:0] data);
      @(posedge clk);
      reg_arvalid <= 1'b1;
      reg_araddr  <= addr;
      @(posedge clk);
      reg_arvalid <= 1'b0;
      @(negedge clk);
      check_value("reg_rvalid", reg_rvalid, 1);
      data = reg_rdata;
   endtask

   task automatic send_task(input task_t t, input logic tied, input cq_slot_t cq,
                            input child_id_t cid);
      @(posedge clk);
      s_wvalid   <= 1'b1;
      s_wdata    <= t;
      s_tied     <= tied;
      s_cq_slot  <= cq;
      s_child_id <= cid;
      @(negedge clk);
      while (!s_wready) @(negedge clk);
      @(posedge clk);
      s_wvalid <= 1'b0;
   endtask

   task automatic send_resp(input tsb_entry_id_t id, input logic ack, input epoch_t epoch,
                            input tq_slot_t tq);
      @(posedge clk);
      task_resp_valid   <= 1'b1;
      task_resp_tsb_id  <= id;
      task_resp_ack     <= ack;
      task_resp_epoch   <= epoch;
      task_resp_tq_slot <= tq;
      @(negedge clk);
      while (!task_resp_ready) @(negedge clk);
      @(posedge clk);
      task_resp_valid <= 1'b0;
   endtask

   task automatic send_retry(input tsb_entry_id_t id, input logic abort, input logic tied);
      @(posedge clk);
      retry_valid  <= 1'b1;
      retry_tsb_id <= id;
      retry_abort  <= abort;
      retry_tied   <= tied;
      @(negedge clk);
      while (!retry_ready) @(negedge clk);
      @(posedge clk);
      retry_valid <= 1'b0;
   endtask

   task automatic get_enq(output task_t d, output tile_id_t tile, output tsb_entry_id_t id,
                          output logic tied);
      @(negedge clk);
      while (enq_data_q.size() == 0) @(negedge clk);
      d    = enq_data_q.pop_front();
      tile = enq_tile_q.pop_front();
      id   = enq_id_q.pop_front();
      tied = enq_tied_q.pop_front();
   endtask

   task automatic wait_empty();
      @(negedge clk);
      while (!empty) @(negedge clk);
   endtask

   task automatic test_reset();
      @(negedge clk);
      check_value("empty", empty, 1);
      check_value("task_enq_valid", task_enq_valid, 0);
      check_value("m_resp_valid", m_resp_valid, 0);
      check_value("almost_full", almost_full, 0);
      check_value("lvt", lvt, 32'hffff_ffff);
      finish_test("reset");
   endtask

   task automatic test_routing();
      int            n_list[4];
      logic [31:0]   key;
      logic [31:0]   n;
      logic [31:0]   r;
      task_t         sent[4];
      logic          sent_tied[4];
      tsb_entry_id_t ids[4];
      task_t         d;
      tile_id_t      tile;
      logic          tied;
      n_list[0] = 1;
      n_list[1] = 3;
      n_list[2] = 4;
      n_list[3] = 16;
      rand_bits(32, key);
      key[3:0] = 4'h0;
      write_reg(`TSB_REG_HASH_KEY, key);
      hash_key_cfg = key;
      for (int c = 0; c < 4; c++) begin
         n = n_list[c];
         write_reg(`TSB_REG_N_TILES, n);
         n_tiles_cfg = n;
         for (int k = 0; k < 4; k++) begin
            rand_task(sent[k]);
            rand_bits(1, r);
            sent_tied[k] = r[0];
            send_task(sent[k], sent_tied[k], cq_slot_t'(k), child_id_t'(k));
         end
         for (int k = 0; k < 4; k++) begin
            get_enq(d, tile, ids[k], tied);
            check_value("task_enq_dest_tile", tile, route_tile(sent[k].locale));
            check_value("task_enq_data", d, sent[k]);
            check_value("task_enq_tied", tied, sent_tied[k]);
            for (int j = 0; j < k; j++) begin
               check_value("task_enq_tsb_id repeated", ids[j] == ids[k], 0);
            end
         end
         for (int k = 0; k < 4; k++) begin
            send_resp(ids[k], 1'b1, '0, '0);
         end
         wait_empty();
      end
      finish_test("routing");
   endtask

   task automatic test_responses();
      task_t         t;
      task_t         d;
      tile_id_t      tile_a;
      tile_id_t      tile_b;
      tile_id_t      exp_tile;
      tsb_entry_id_t id_a;
      tsb_entry_id_t id_b;
      logic          tied;
      logic [29:0]   got;
      // let responses from earlier tests drain
      repeat (4) @(negedge clk);
      mresp_q.delete();
      rand_task(t);
      exp_tile = tile_id_t'(route_tile(t.locale));
      send_task(t, 1'b1, 5'h13, 2'd2);
      get_enq(d, tile_a, id_a, tied);
      check_value("task_enq_dest_tile", tile_a, exp_tile);
      rand_task(t);
      send_task(t, 1'b0, 5'h07, 2'd1);
      get_enq(d, tile_b, id_b, tied);
      send_resp(id_a, 1'b1, 8'h5a, 6'h21);
      @(negedge clk);
      while (mresp_q.size() == 0) @(negedge clk);
      got = mresp_q.pop_front();
      check_value("m_resp fields", got, {1'b1, id_a, 8'h5a, 6'h21, exp_tile, 5'h13, 2'd2});
      send_resp(id_b, 1'b1, 8'h33, 6'h0c);
      repeat (8) @(negedge clk);
      check_value("m_resp count for untied task", mresp_q.size(), 0);
      check_value("empty", empty, 1);
      finish_test("responses");
   endtask

   task automatic test_retry();
      task_t         t;
      task_t         d;
      tile_id_t      tile;
      tile_id_t      tile2;
      tsb_entry_id_t id;
      tsb_entry_id_t id2;
      logic          tied;
      logic [29:0]   got;
      logic [31:0]   bitmap;
      rand_task(t);
      send_task(t, 1'b0, 5'h03, 2'd0);
      get_enq(d, tile, id, tied);
      check_value("task_enq_dest_tile", tile, route_tile(t.locale));
      send_retry(id, 1'b0, 1'b1);
      get_enq(d, tile2, id2, tied);
      check_value("replay task_enq_data", d, t);
      check_value("replay task_enq_dest_tile", tile2, route_tile(t.locale));
      check_value("replay task_enq_tsb_id", id2, id);
      check_value("replay task_enq_tied", tied, 1);
      // entry is tied now, so a nack reports back and keeps it
      send_resp(id, 1'b0, 8'hc4, 6'h15);
      @(negedge clk);
      while (mresp_q.size() == 0) @(negedge clk);
      got = mresp_q.pop_front();
      check_value("m_resp fields after replay", got,
                  {1'b0, id, 8'hc4, 6'h15, tile_id_t'(route_tile(t.locale)), 5'h03, 2'd0});
      read_reg(`TSB_REG_ENTRY_VALID, bitmap);
      check_value("entry_valid bitmap", bitmap, 32'd1 << id);
      send_retry(id, 1'b1, 1'b0);
      repeat (8) @(negedge clk);
      check_value("enqueues after abort", enq_data_q.size(), 0);
      read_reg(`TSB_REG_ENTRY_VALID, bitmap);
      check_value("entry_valid bitmap after abort", bitmap, 0);
      check_value("empty", empty, 1);
      finish_test("retry");
   endtask

   task automatic test_fill();
      task_t         sent;
      task_t         extra;
      task_t         d;
      tile_id_t      tile;
      tsb_entry_id_t id;
      logic          tied;
      logic [31:0]   bitmap;
      @(posedge clk);
      stall_en <= 1'b1;
      for (int k = 0; k < 16; k++) begin
         rand_task(sent);
         send_task(sent, 1'b0, cq_slot_t'(k), child_id_t'(k));
         get_enq(d, tile, id, tied);
         check_value("task_enq_tsb_id", id, k);
         check_value("task_enq_data", d, sent);
         check_value("almost_full", almost_full, k + 1 > 12);
      end
      read_reg(`TSB_REG_ENTRY_VALID, bitmap);
      check_value("entry_valid bitmap", bitmap, 32'h0000_ffff);
      // a 17th task waits in the hash stage
      rand_task(extra);
      send_task(extra, 1'b0, 5'h1f, 2'd3);
      repeat (10) @(negedge clk);
      check_value("enqueues while full", enq_data_q.size(), 0);
      check_value("s_wready while full", s_wready, 0);
      @(posedge clk);
      stall_en <= 1'b0;
      send_resp(4'd0, 1'b1, '0, '0);
      get_enq(d, tile, id, tied);
      check_value("late task_enq_tsb_id", id, 0);
      check_value("late task_enq_data", d, extra);
      for (int k = 0; k < 16; k++) begin
         send_resp(tsb_entry_id_t'(k), 1'b1, '0, '0);
      end
      wait_empty();
      check_value("almost_full", almost_full, 0);
      finish_test("fill");
   endtask

   task automatic test_lvt();
      task_t         t;
      task_t         d;
      tile_id_t      tile;
      logic          tied;
      ts_t           held_ts[5];
      tsb_entry_id_t ids[5];
      ts_t           exp_min;
      for (int k = 0; k < 5; k++) begin
         rand_task(t);
         held_ts[k] = t.ts;
         send_task(t, 1'b0, '0, '0);
         get_enq(d, tile, ids[k], tied);
      end
      repeat (40) @(negedge clk);
      exp_min = '1;
      for (int k = 0; k < 5; k++) begin
         if (held_ts[k] < exp_min) exp_min = held_ts[k];
      end
      check_value("lvt with 5 entries", lvt, exp_min);
      send_resp(ids[0], 1'b1, '0, '0);
      send_resp(ids[1], 1'b1, '0, '0);
      repeat (40) @(negedge clk);
      exp_min = '1;
      for (int k = 2; k < 5; k++) begin
         if (held_ts[k] < exp_min) exp_min = held_ts[k];
      end
      check_value("lvt with 3 entries", lvt, exp_min);
      for (int k = 2; k < 5; k++) begin
         send_resp(ids[k], 1'b1, '0, '0);
      end
      repeat (40) @(negedge clk);
      check_value("lvt when empty", lvt, 32'hffff_ffff);
      finish_test("lvt");
   endtask

   initial begin
      rstn              = 1'b0;
      s_wvalid          = 1'b0;
      s_wdata           = '0;
      s_tied            = 1'b0;
      s_cq_slot         = '0;
      s_child_id        = '0;
      reg_wvalid        = 1'b0;
      reg_waddr         = '0;
      reg_wdata         = '0;
      reg_arvalid       = 1'b0;
      reg_araddr        = '0;
      task_enq_ready    = 1'b1;
      retry_valid       = 1'b0;
      retry_tsb_id      = '0;
      retry_abort       = 1'b0;
      retry_tied        = 1'b0;
      task_resp_valid   = 1'b0;
      task_resp_ack     = 1'b0;
      task_resp_tsb_id  = '0;
      task_resp_epoch   = '0;
      task_resp_tq_slot = '0;
      m_resp_ready      = 1'b1;
      repeat (16) @(posedge clk);
      rstn <= 1'b1;
      test_reset();
      test_routing();
      test_responses();
      test_retry();
      test_fill();
      test_lvt();
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: design/tsb_top.sv
`timescale 1ns/1ps
`include "swarm_cfg.svh"

module tsb_top (
   input  logic                         clk,
   input  logic                         rstn,

   input  logic                         s_wvalid,
   output logic                         s_wready,
   input  swarm_pkg::task_t             s_wdata,
   input  logic                         s_tied,
   input  swarm_pkg::cq_slot_t          s_cq_slot,
   input  swarm_pkg::child_id_t         s_child_id,

   input  logic                         reg_wvalid,
   input  swarm_pkg::reg_addr_t         reg_waddr,
   input  swarm_pkg::reg_word_u         reg_wdata,
   input  logic                         reg_arvalid,
   input  swarm_pkg::reg_addr_t         reg_araddr,
   output logic                         reg_rvalid,
   output swarm_pkg::reg_data_t         reg_rdata,

   output logic                         task_enq_valid,
   input  logic                         task_enq_ready,
   output swarm_pkg::task_t             task_enq_data,
   output logic                         task_enq_tied,
   output swarm_pkg::tile_id_t          task_enq_dest_tile,
   output swarm_pkg::tsb_entry_id_t     task_enq_tsb_id,

   input  logic                         retry_valid,
   output logic                         retry_ready,
   input  swarm_pkg::tsb_entry_id_t     retry_tsb_id,
   input  logic                         retry_abort,
   input  logic                         retry_tied,

   input  logic                         task_resp_valid,
   output logic                         task_resp_ready,
   input  logic                         task_resp_ack,
   input  swarm_pkg::tsb_entry_id_t     task_resp_tsb_id,
   input  swarm_pkg::epoch_t            task_resp_epoch,
   input  swarm_pkg::tq_slot_t          task_resp_tq_slot,

   output logic                         m_resp_valid,
   input  logic                         m_resp_ready,
   output logic                         m_resp_ack,
   output swarm_pkg::tsb_entry_id_t     m_tsb_slot,
   output swarm_pkg::epoch_t            m_epoch,
   output swarm_pkg::tq_slot_t          m_tq_slot,
   output swarm_pkg::tile_id_t          m_tile_id,
   output swarm_pkg::cq_slot_t          m_cq_slot,
   output swarm_pkg::child_id_t         m_child_id,

   output logic                         almost_full,
   output logic                         empty,
   output swarm_pkg::ts_t               lvt
);
   import swarm_pkg::*;

   logic      h_valid;
   logic      h_ready;
   task_t     h_data;
   logic      h_tied;
   cq_slot_t  h_cq_slot;
   child_id_t h_child_id;
   tile_id_t  h_dest_tile;

   logic [2**`TSB_LOG_SIZE-1:0]             entry_valid;
   logic [`TS_WIDTH*(2**`TSB_LOG_SIZE)-1:0] entry_ts;

   tile_hash tile_hash_inst (
      .clk, .rstn,
      .s_wvalid, .s_wready, .s_wdata, .s_tied, .s_cq_slot, .s_child_id,
      .reg_wvalid, .reg_waddr, .reg_wdata,
      .h_valid, .h_ready, .h_data, .h_tied, .h_cq_slot, .h_child_id, .h_dest_tile
   );

   tsb tsb_inst (
      .clk, .rstn,
      .h_valid, .h_ready, .h_data, .h_tied, .h_cq_slot, .h_child_id, .h_dest_tile,
      .task_enq_valid, .task_enq_ready, .task_enq_data, .task_enq_tied,
      .task_enq_dest_tile, .task_enq_tsb_id,
      .retry_valid, .retry_ready, .retry_tsb_id, .retry_abort, .retry_tied,
      .task_resp_valid, .task_resp_ready, .task_resp_ack, .task_resp_tsb_id,
      .task_resp_epoch, .task_resp_tq_slot,
      .m_resp_valid, .m_resp_ready, .m_resp_ack, .m_tsb_slot, .m_epoch,
      .m_tq_slot, .m_tile_id, .m_cq_slot, .m_child_id,
      .reg_arvalid, .reg_araddr, .reg_rvalid, .reg_rdata,
      .almost_full, .empty, .entry_valid, .entry_ts
   );

   lvt_scan lvt_scan_inst (
      .clk, .rstn,
      .entry_valid, .entry_ts,
      .lvt
   );

endmodule

// File: design/lvt_scan.sv
`timescale 1ns/1ps
`include "swarm_cfg.svh"

module lvt_scan (
   input  logic                                    clk,
   input  logic                                    rstn,
   input  logic [2**`TSB_LOG_SIZE-1:0]             entry_valid,
   input  logic [`TS_WIDTH*(2**`TSB_LOG_SIZE)-1:0] entry_ts,
   output swarm_pkg::ts_t                          lvt
);
   import swarm_pkg::*;

   logic [`TSB_LOG_SIZE-1:0] cur_idx;
   ts_t                      cur_ts;
   logic                     cur_valid;
   ts_t                      rolling;

   assign cur_ts    = entry_ts[cur_idx*`TS_WIDTH +: `TS_WIDTH];
   assign cur_valid = entry_valid[cur_idx];

   // one entry per cycle, result published on wrap
   always_ff @(posedge clk) begin
      if (!rstn) begin
         cur_idx <= '0;
         rolling <= TS_NONE;
         lvt     <= TS_NONE;
      end else begin
         cur_idx <= cur_idx + 1'b1;
         if (cur_idx == '0) begin
            lvt     <= rolling;
            // restart the pass at entry 0
            rolling <= cur_valid ? cur_ts : TS_NONE;
         end else if (cur_valid && cur_ts < rolling) begin
            rolling <= cur_ts;
         end
      end
   end

endmodule

// File: design/tsb.sv
`timescale 1ns/1ps
`include "swarm_cfg.svh"

module tsb (
   input  logic                         clk,
   input  logic                         rstn,

   // hashed task in
   input  logic                         h_valid,
   output logic                         h_ready,
   input  swarm_pkg::task_t             h_data,
   input  logic                         h_tied,
   input  swarm_pkg::cq_slot_t          h_cq_slot,
   input  swarm_pkg::child_id_t         h_child_id,
   input  swarm_pkg::tile_id_t          h_dest_tile,

   // enqueue to the tile
   output logic                         task_enq_valid,
   input  logic                         task_enq_ready,
   output swarm_pkg::task_t             task_enq_data,
   output logic                         task_enq_tied,
   output swarm_pkg::tile_id_t          task_enq_dest_tile,
   output swarm_pkg::tsb_entry_id_t     task_enq_tsb_id,

   input  logic                         retry_valid,
   output logic                         retry_ready,
   input  swarm_pkg::tsb_entry_id_t     retry_tsb_id,
   input  logic                         retry_abort,
   input  logic                         retry_tied,

   input  logic                         task_resp_valid,
   output logic                         task_resp_ready,
   input  logic                         task_resp_ack,
   input  swarm_pkg::tsb_entry_id_t     task_resp_tsb_id,
   input  swarm_pkg::epoch_t            task_resp_epoch,
   input  swarm_pkg::tq_slot_t          task_resp_tq_slot,

   // back to the child manager
   output logic                         m_resp_valid,
   input  logic                         m_resp_ready,
   output logic                         m_resp_ack,
   output swarm_pkg::tsb_entry_id_t     m_tsb_slot,
   output swarm_pkg::epoch_t            m_epoch,
   output swarm_pkg::tq_slot_t          m_tq_slot,
   output swarm_pkg::tile_id_t          m_tile_id,
   output swarm_pkg::cq_slot_t          m_cq_slot,
   output swarm_pkg::child_id_t         m_child_id,

   input  logic                         reg_arvalid,
   input  swarm_pkg::reg_addr_t         reg_araddr,
   output logic                         reg_rvalid,
   output swarm_pkg::reg_data_t         reg_rdata,

   output logic                         almost_full,
   output logic                         empty,
   output logic [2**`TSB_LOG_SIZE-1:0]  entry_valid,
   output logic [`TS_WIDTH*(2**`TSB_LOG_SIZE)-1:0] entry_ts
);
   import swarm_pkg::*;

   localparam int TSB_SIZE = 2 ** `TSB_LOG_SIZE;
   localparam int ALMOST_FULL_LIMIT = TSB_SIZE - 4;

   typedef logic [`TSB_LOG_SIZE:0] occ_t;

   task_t         entry_task     [TSB_SIZE];
   tile_id_t      entry_tile     [TSB_SIZE];
   logic          entry_tied     [TSB_SIZE];
   cq_slot_t      entry_cq_slot  [TSB_SIZE];
   child_id_t     entry_child_id [TSB_SIZE];

   tsb_entry_id_t free_id;
   occ_t          occupancy;
   logic          enq_open;
   logic          h_take;
   logic          retry_take;
   logic          replay_take;
   logic          abort_take;
   logic          resp_take;
   logic          ack_take;

   // lowest free entry
   always_comb begin
      free_id = '0;
      for (int i = TSB_SIZE - 1; i >= 0; i--) begin
         if (!entry_valid[i]) begin
            free_id = tsb_entry_id_t'(i);
         end
      end
   end

   assign enq_open        = !task_enq_valid || task_enq_ready;
   assign h_ready         = enq_open && !entry_valid[free_id];
   // new tasks win over retries
   assign retry_ready     = enq_open && !(h_valid && h_ready);
   assign task_resp_ready = !m_resp_valid;

   assign h_take      = h_valid && h_ready;
   assign retry_take  = retry_valid && retry_ready;
   assign replay_take = retry_take && !retry_abort;
   assign abort_take  = retry_take && retry_abort;
   assign resp_take   = task_resp_valid && task_resp_ready;
   assign ack_take    = resp_take && task_resp_ack;

   always_ff @(posedge clk) begin
      if (h_take) begin
         entry_task[free_id]     <= h_data;
         entry_tile[free_id]     <= h_dest_tile;
         entry_tied[free_id]     <= h_tied;
         entry_cq_slot[free_id]  <= h_cq_slot;
         entry_child_id[free_id] <= h_child_id;
      end else if (replay_take) begin
         entry_tied[retry_tsb_id] <= retry_tied;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         entry_valid <= '0;
      end else begin
         for (int i = 0; i < TSB_SIZE; i++) begin
            if (h_take && free_id == tsb_entry_id_t'(i)) begin
               entry_valid[i] <= 1'b1;
            end else if (abort_take && retry_tsb_id == tsb_entry_id_t'(i)) begin
               entry_valid[i] <= 1'b0;
            end else if (ack_take && task_resp_tsb_id == tsb_entry_id_t'(i)) begin
               entry_valid[i] <= 1'b0;
            end
         end
      end
   end

   for (genvar g = 0; g < TSB_SIZE; g++) begin : g_entry_ts
      assign entry_ts[g*`TS_WIDTH +: `TS_WIDTH] = entry_task[g].ts;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_enq_valid <= 1'b0;
      end else if (h_take || replay_take) begin
         task_enq_valid <= 1'b1;
      end else if (task_enq_ready) begin
         task_enq_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (h_take) begin
         task_enq_data      <= h_data;
         task_enq_tied      <= h_tied;
         task_enq_dest_tile <= h_dest_tile;
         task_enq_tsb_id    <= free_id;
      end else if (replay_take) begin
         // replay the stored task with the new tied flag
         task_enq_data      <= entry_task[retry_tsb_id];
         task_enq_tied      <= retry_tied;
         task_enq_dest_tile <= entry_tile[retry_tsb_id];
         task_enq_tsb_id    <= retry_tsb_id;
      end
   end

   // only tied entries report back
   always_ff @(posedge clk) begin
      if (!rstn) begin
         m_resp_valid <= 1'b0;
      end else if (resp_take && entry_tied[task_resp_tsb_id]) begin
         m_resp_valid <= 1'b1;
      end else if (m_resp_ready) begin
         m_resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (resp_take) begin
         m_resp_ack <= task_resp_ack;
         m_tsb_slot <= task_resp_tsb_id;
         m_epoch    <= task_resp_epoch;
         m_tq_slot  <= task_resp_tq_slot;
         m_tile_id  <= entry_tile[task_resp_tsb_id];
         m_cq_slot  <= entry_cq_slot[task_resp_tsb_id];
         m_child_id <= entry_child_id[task_resp_tsb_id];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         occupancy <= '0;
      end else begin
         occupancy <= occupancy + occ_t'(h_take) - occ_t'(ack_take) - occ_t'(abort_take);
      end
   end

   assign almost_full = (occupancy > occ_t'(ALMOST_FULL_LIMIT));
   assign empty       = (entry_valid == '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            `TSB_REG_ENTRY_VALID: reg_rdata <= reg_data_t'(entry_valid);
            default:              reg_rdata <= '0;
         endcase
      end
   end

endmodule

// File: design/tile_hash.sv
`timescale 1ns/1ps
`include "swarm_cfg.svh"

module tile_hash (
   input  logic                      clk,
   input  logic                      rstn,

   // child task in
   input  logic                      s_wvalid,
   output logic                      s_wready,
   input  swarm_pkg::task_t          s_wdata,
   input  logic                      s_tied,
   input  swarm_pkg::cq_slot_t       s_cq_slot,
   input  swarm_pkg::child_id_t      s_child_id,

   // register writes
   input  logic                      reg_wvalid,
   input  swarm_pkg::reg_addr_t      reg_waddr,
   input  swarm_pkg::reg_word_u      reg_wdata,

   // task with its destination tile
   output logic                      h_valid,
   input  logic                      h_ready,
   output swarm_pkg::task_t          h_data,
   output logic                      h_tied,
   output swarm_pkg::cq_slot_t       h_cq_slot,
   output swarm_pkg::child_id_t      h_child_id,
   output swarm_pkg::tile_id_t       h_dest_tile
);
   import swarm_pkg::*;

   n_tiles_t  n_tiles;
   n_tiles_t  n_eff;
   hash_key_t hash_key;
   hash_key_t hashed;
   tile_id_t  dest_tile;
   logic      s_take;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_tiles  <= n_tiles_t'(`N_TILES_RESET);
         hash_key <= '0;
      end else if (reg_wvalid) begin
         case (reg_waddr)
            `TSB_REG_N_TILES:  n_tiles  <= reg_wdata.n_tiles.count;
            `TSB_REG_HASH_KEY: hash_key <= reg_wdata.hash_key.key;
            default: ;
         endcase
      end
   end

   // out of range counts fall back to the full tile set
   assign n_eff = (n_tiles == '0 || n_tiles > n_tiles_t'(`N_TILES_MAX)) ?
                  n_tiles_t'(`N_TILES_MAX) : n_tiles;

   // low locale bits stay inside a tile
   assign hashed    = s_wdata.locale[`LOCALE_WIDTH-1:`HASH_LOW_BITS] ^ hash_key;
   assign dest_tile = tile_id_t'(hashed % hash_key_t'(n_eff));

   // one deep, refills while draining
   assign s_wready = !h_valid || h_ready;
   assign s_take   = s_wvalid && s_wready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         h_valid <= 1'b0;
      end else if (s_take) begin
         h_valid <= 1'b1;
      end else if (h_ready) begin
         h_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (s_take) begin
         h_data      <= s_wdata;
         h_tied      <= s_tied;
         h_cq_slot   <= s_cq_slot;
         h_child_id  <= s_child_id;
         h_dest_tile <= dest_tile;
      end
   end

endmodule

// File: design/swarm_pkg.sv
`include "swarm_cfg.svh"

package swarm_pkg;

   typedef logic [`TS_WIDTH-1:0]              ts_t;
   typedef logic [`LOCALE_WIDTH-1:0]          locale_t;
   typedef logic [`ARG_WIDTH-1:0]             arg_t;

   // all ones marks an empty timestamp
   localparam ts_t TS_NONE = '1;

   typedef struct packed {
      ts_t     ts;
      locale_t locale;
      arg_t    arg;
   } task_t;

   typedef logic [$clog2(`N_TILES_MAX)-1:0]   tile_id_t;
   typedef logic [`TSB_LOG_SIZE-1:0]          tsb_entry_id_t;
   typedef logic [`EPOCH_WIDTH-1:0]           epoch_t;
   typedef logic [`TQ_SLOT_WIDTH-1:0]         tq_slot_t;
   typedef logic [`CQ_SLOT_WIDTH-1:0]         cq_slot_t;
   typedef logic [`CHILD_ID_WIDTH-1:0]        child_id_t;

   typedef logic [`REG_ADDR_WIDTH-1:0]        reg_addr_t;
   typedef logic [`REG_DATA_WIDTH-1:0]        reg_data_t;

   // tile count holds one more bit than a tile id, so 16 fits
   typedef logic [$clog2(`N_TILES_MAX):0]     n_tiles_t;
   typedef logic [`REG_DATA_WIDTH-`HASH_LOW_BITS-1:0] hash_key_t;

   // one write word, two readings
   typedef union packed {
      struct packed {
         logic [`REG_DATA_WIDTH-$bits(n_tiles_t)-1:0] rsvd;
         n_tiles_t                                    count;
      } n_tiles;
      struct packed {
         hash_key_t                  key;
         logic [`HASH_LOW_BITS-1:0]  zero;
      } hash_key;
   } reg_word_u;

endpackage

// File: design/swarm_cfg.svh
`ifndef SWARM_CFG_SVH
`define SWARM_CFG_SVH

// buffer size and tile limits
`define TSB_LOG_SIZE         4
`define N_TILES_MAX          16
`define N_TILES_RESET        4

// field widths
`define TS_WIDTH             32
`define LOCALE_WIDTH         32
`define ARG_WIDTH            32
`define EPOCH_WIDTH          8
`define TQ_SLOT_WIDTH        6
`define CQ_SLOT_WIDTH        5
`define CHILD_ID_WIDTH       2
`define HASH_LOW_BITS        4
`define REG_ADDR_WIDTH       8
`define REG_DATA_WIDTH       32

// register map
`define TSB_REG_N_TILES      8'h00
`define TSB_REG_HASH_KEY     8'h04
`define TSB_REG_ENTRY_VALID  8'h08

`endif
